// ==== logic/tl_settings.svh ====
// timing constants and widths for the intersection controller
// include wherever a width or default length is needed
`ifndef TL_SETTINGS_SVH
`define TL_SETTINGS_SVH

// countdown and duration width
`define TL_CNT_W 11

// display value width, wide enough for hour*100+minute
`define TL_DISP_W 14

// lengths after reset, in seconds
`define TL_RG_DEFAULT 30
`define TL_Y_DEFAULT 5

// pedestrian interrupt yellow
`define TL_INT_LEN 5

// peak hours, both ends inclusive
`define TL_PEAK_AM_LO 7
`define TL_PEAK_AM_HI 9
`define TL_PEAK_PM_LO 17
`define TL_PEAK_PM_HI 19

`endif

// ==== logic/tl_pkg.sv ====
// phase and operator mode types for the intersection controller
`default_nettype none

package tl_pkg;

  // controller phase, yellows follow each green
  typedef enum logic [3:0] {
    NIGHT = 4'd0,
    G1    = 4'd1,
    G1Y   = 4'd2,
    G1L   = 4'd3,
    G1LY  = 4'd4,
    G2    = 4'd5,
    G2Y   = 4'd6,
    G2L   = 4'd7,
    G2LY  = 4'd8,
    INT1  = 4'd9,
    INT2  = 4'd10
  } phase_t;

  // operator mode switch
  typedef enum logic [1:0] {
    RUN        = 2'd0,
    NIGHT_MODE = 2'd1,
    SET_RG     = 2'd2,
    SET_Y      = 2'd3
  } mode_t;

endpackage

`default_nettype wire

// ==== logic/input_sync.sv ====
// synchronizes the keys and the seconds strobe, one-cycle pulse on release
`default_nettype none
`timescale 1ns/1ps

module input_sync (
  input  logic clk,
  input  logic rst_n,
  input  logic i_key_plus,
  input  logic i_key_sub,
  input  logic i_tick,
  output logic o_plus_pulse,
  output logic o_sub_pulse,
  output logic o_sec_pulse
);

  // bit 0 plus, bit 1 sub, bit 2 tick
  logic [2:0] raw;
  logic [2:0] sync_q;
  logic [2:0] sync_qq;
  logic [2:0] prev_q;
  logic [2:0] pulse_q;

  assign raw = {i_tick, i_key_sub, i_key_plus};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= '0;
      sync_qq <= '0;
      prev_q  <= '0;
      pulse_q <= '0;
    end else begin
      sync_q  <= raw;
      sync_qq <= sync_q;
      prev_q  <= sync_qq;
      // falling edge of the synchronized level
      pulse_q <= prev_q & ~sync_qq;
    end
  end

  assign o_plus_pulse = pulse_q[0];
  assign o_sub_pulse  = pulse_q[1];
  assign o_sec_pulse  = pulse_q[2];

endmodule

`default_nettype wire

// ==== logic/duration_regs.sv ====
// adjustable green/red and yellow lengths, stepped by the keys in setting modes
`default_nettype none
`timescale 1ns/1ps
`include "tl_settings.svh"

module duration_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  tl_pkg::mode_t        i_mode,
  input  logic                 i_plus_pulse,
  input  logic                 i_sub_pulse,
  output logic [`TL_CNT_W-1:0] o_rg_len,
  output logic [`TL_CNT_W-1:0] o_y_len
);

  import tl_pkg::*;

  logic [`TL_CNT_W-1:0] rg_q;
  logic [`TL_CNT_W-1:0] y_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rg_q <= `TL_CNT_W'(`TL_RG_DEFAULT);
    end else if (i_mode == SET_RG) begin
      // plain wrap at the word width
      if (i_plus_pulse) begin
        rg_q <= rg_q + 1'b1;
      end else if (i_sub_pulse) begin
        rg_q <= rg_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y_q <= `TL_CNT_W'(`TL_Y_DEFAULT);
    end else if (i_mode == SET_Y) begin
      if (i_plus_pulse) begin
        y_q <= y_q + 1'b1;
      end else if (i_sub_pulse) begin
        y_q <= y_q - 1'b1;
      end
    end
  end

  assign o_rg_len = rg_q;
  assign o_y_len  = y_q;

endmodule

`default_nettype wire

// ==== logic/day_clock.sv ====
// time-of-day counter driven by the seconds pulse, flags the peak hours
`default_nettype none
`timescale 1ns/1ps
`include "tl_settings.svh"

module day_clock (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_sec_pulse,
  output logic [4:0] o_hour,
  output logic [5:0] o_minute,
  output logic       o_peak
);

  logic [5:0] sec_q;
  logic [5:0] min_q;
  logic [4:0] hour_q;

  // runs in every mode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sec_q  <= '0;
      min_q  <= '0;
      hour_q <= '0;
    end else if (i_sec_pulse) begin
      if (sec_q == 6'd59) begin
        sec_q <= '0;
        if (min_q == 6'd59) begin
          min_q  <= '0;
          hour_q <= (hour_q == 5'd23) ? 5'd0 : hour_q + 1'b1;
        end else begin
          min_q <= min_q + 1'b1;
        end
      end else begin
        sec_q <= sec_q + 1'b1;
      end
    end
  end

  assign o_peak = ((hour_q >= `TL_PEAK_AM_LO) && (hour_q <= `TL_PEAK_AM_HI)) ||
                  ((hour_q >= `TL_PEAK_PM_LO) && (hour_q <= `TL_PEAK_PM_HI));

  assign o_hour   = hour_q;
  assign o_minute = min_q;

endmodule

`default_nettype wire

// ==== logic/phase_ctrl.sv ====
// phase FSM with per-phase countdown and pedestrian interrupts
// the count is loaded one cycle after a phase is entered
`default_nettype none
`timescale 1ns/1ps
`include "tl_settings.svh"

module phase_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  tl_pkg::mode_t        i_mode,
  input  logic                 i_plus_pulse,
  input  logic                 i_sub_pulse,
  input  logic                 i_sec_pulse,
  input  logic [`TL_CNT_W-1:0] i_rg_len,
  input  logic [`TL_CNT_W-1:0] i_y_len,
  input  logic                 i_peak,
  output tl_pkg::phase_t       o_phase,
  output logic [`TL_CNT_W-1:0] o_remain,
  output logic [`TL_CNT_W-1:0] o_rg_eff
);

  import tl_pkg::*;

  phase_t               phase_q;
  phase_t               phase_nx;
  logic [`TL_CNT_W-1:0] remain_q;
  logic [`TL_CNT_W-1:0] load_len;
  logic                 load_q;
  logic                 int_start_q;
  logic                 is_run;
  logic                 is_night;
  logic                 int_req;
  logic                 advance;

  assign is_run   = (i_mode == RUN);
  assign is_night = (i_mode == NIGHT_MODE);
  assign int_req  = is_run && !int_start_q && (i_sub_pulse || i_plus_pulse);
  // no second step right after a load
  assign advance  = is_run && (remain_q == '0) && !load_q && !int_start_q;

  // through greens doubled in peak hours
  assign o_rg_eff = (i_peak && ((phase_q == G1) || (phase_q == G2))) ?
                    {i_rg_len[`TL_CNT_W-2:0], 1'b0} : i_rg_len;

  always_comb begin
    case (phase_q)
      G1:      phase_nx = G1Y;
      G1Y:     phase_nx = G1L;
      G1L:     phase_nx = G1LY;
      G1LY:    phase_nx = G2;
      G2:      phase_nx = G2Y;
      G2Y:     phase_nx = G2L;
      G2L:     phase_nx = G2LY;
      INT2:    phase_nx = G2;
      default: phase_nx = G1;
    endcase
  end

  always_comb begin
    case (phase_q)
      G1, G2, G1L, G2L: load_len = o_rg_eff;
      INT1, INT2:       load_len = `TL_CNT_W'(`TL_INT_LEN);
      default:          load_len = i_y_len;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q     <= NIGHT;
      load_q      <= 1'b0;
      int_start_q <= 1'b0;
    end else if (is_night) begin
      phase_q     <= NIGHT;
      load_q      <= 1'b0;
      int_start_q <= 1'b0;
    end else if (int_req) begin
      // sub wins if both keys land together
      phase_q     <= i_sub_pulse ? INT1 : INT2;
      int_start_q <= 1'b1;
      load_q      <= 1'b0;
    end else begin
      int_start_q <= 1'b0;
      load_q      <= advance;
      if (advance) begin
        phase_q <= phase_nx;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain_q <= '0;
    end else if (is_night || (phase_q == NIGHT)) begin
      remain_q <= '0;
    end else if (load_q || int_start_q) begin
      remain_q <= load_len;
    end else if (is_run && i_sec_pulse && (remain_q != '0)) begin
      remain_q <= remain_q - 1'b1;
    end
  end

  assign o_phase  = phase_q;
  assign o_remain = remain_q;

  a_phase_legal: assert property (@(posedge clk) disable iff (!rst_n)
    phase_q inside {NIGHT, G1, G1Y, G1L, G1LY, G2, G2Y, G2L, G2LY, INT1, INT2});

  // setting modes hold the phase and the count
  a_set_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    (!is_run && !is_night && !load_q && !int_start_q) |=>
      ($stable(phase_q) && $stable(remain_q)));

endmodule

`default_nettype wire

// ==== logic/lamp_decode.sv ====
// maps the controller phase onto the twelve lamp outputs
`default_nettype none
`timescale 1ns/1ps

module lamp_decode (
  input  tl_pkg::phase_t i_phase,
  output logic           o_r1,
  output logic           o_y1,
  output logic           o_g1,
  output logic           o_r1_l,
  output logic           o_y1_l,
  output logic           o_g1_l,
  output logic           o_r2,
  output logic           o_y2,
  output logic           o_g2,
  output logic           o_r2_l,
  output logic           o_y2_l,
  output logic           o_g2_l
);

  import tl_pkg::*;

  // r1 y1 g1, r1l y1l g1l, r2 y2 g2, r2l y2l g2l
  logic [11:0] lamps;

  always_comb begin
    case (i_phase)
      NIGHT:      lamps = 12'b010_010_010_010;
      G1:         lamps = 12'b001_100_100_100;
      G1Y, INT1:  lamps = 12'b010_100_100_100;
      G1L:        lamps = 12'b100_001_100_100;
      G1LY:       lamps = 12'b100_010_100_100;
      G2:         lamps = 12'b100_100_001_100;
      G2Y, INT2:  lamps = 12'b100_100_010_100;
      G2L:        lamps = 12'b100_100_100_001;
      G2LY:       lamps = 12'b100_100_100_010;
      default:    lamps = 12'b000_000_000_000;
    endcase
  end

  assign {o_r1, o_y1, o_g1}       = lamps[11:9];
  assign {o_r1_l, o_y1_l, o_g1_l} = lamps[8:6];
  assign {o_r2, o_y2, o_g2}       = lamps[5:3];
  assign {o_r2_l, o_y2_l, o_g2_l} = lamps[2:0];

endmodule

`default_nettype wire

// ==== logic/display_select.sv ====
// remaining-time values for the two displays, or setting and clock in setting modes
`default_nettype none
`timescale 1ns/1ps
`include "tl_settings.svh"

module display_select (
  input  tl_pkg::mode_t         i_mode,
  input  tl_pkg::phase_t        i_phase,
  input  logic [`TL_CNT_W-1:0]  i_remain,
  input  logic [`TL_CNT_W-1:0]  i_rg_eff,
  input  logic [`TL_CNT_W-1:0]  i_rg_len,
  input  logic [`TL_CNT_W-1:0]  i_y_len,
  input  logic [4:0]            i_hour,
  input  logic [5:0]            i_minute,
  output logic [`TL_DISP_W-1:0] o_disp_main,
  output logic [`TL_DISP_W-1:0] o_disp_side
);

  import tl_pkg::*;

  logic [`TL_DISP_W-1:0] r;
  logic [`TL_DISP_W-1:0] y;
  logic [`TL_DISP_W-1:0] g;
  logic [`TL_DISP_W-1:0] clock_val;
  logic [`TL_DISP_W-1:0] main_run;
  logic [`TL_DISP_W-1:0] side_run;

  assign r = `TL_DISP_W'(i_remain);
  assign y = `TL_DISP_W'(i_y_len);
  assign g = `TL_DISP_W'(i_rg_eff);

  // hhmm as a plain binary number
  assign clock_val = `TL_DISP_W'(i_hour) * `TL_DISP_W'(100) + `TL_DISP_W'(i_minute);

  // main follows road 1, side follows road 2
  always_comb begin
    case (i_phase)
      G1, G1L, G2L: main_run = r + y;
      G2:           main_run = r + y + y + g;
      G2Y:          main_run = r + y + g;
      default:      main_run = r;
    endcase
  end

  always_comb begin
    case (i_phase)
      G1:           side_run = r + y + y + g;
      G1Y:          side_run = r + y + g;
      G1L, G2, G2L: side_run = r + y;
      default:      side_run = r;
    endcase
  end

  always_comb begin
    case (i_mode)
      SET_RG: o_disp_main = `TL_DISP_W'(i_rg_len);
      SET_Y:  o_disp_main = y;
      default: o_disp_main = main_run;
    endcase
    o_disp_side = ((i_mode == SET_RG) || (i_mode == SET_Y)) ? clock_val : side_run;
  end

endmodule

`default_nettype wire

// ==== logic/tl_top.sv ====
// two-road intersection signal controller, top level
// takes a one-second strobe on i_tick, lamps and displays leave as parallel ports
`default_nettype none
`timescale 1ns/1ps
`include "tl_settings.svh"

module tl_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  tl_pkg::mode_t         i_mode,
  input  logic                  i_key_plus,
  input  logic                  i_key_sub,
  input  logic                  i_tick,
  output logic                  o_r1,
  output logic                  o_y1,
  output logic                  o_g1,
  output logic                  o_r1_l,
  output logic                  o_y1_l,
  output logic                  o_g1_l,
  output logic                  o_r2,
  output logic                  o_y2,
  output logic                  o_g2,
  output logic                  o_r2_l,
  output logic                  o_y2_l,
  output logic                  o_g2_l,
  output logic [`TL_DISP_W-1:0] o_disp_main,
  output logic [`TL_DISP_W-1:0] o_disp_side
);

  import tl_pkg::*;

  logic                 plus_pulse;
  logic                 sub_pulse;
  logic                 sec_pulse;
  logic [`TL_CNT_W-1:0] rg_len;
  logic [`TL_CNT_W-1:0] y_len;
  logic [4:0]           hour;
  logic [5:0]           minute;
  logic                 peak;
  phase_t               phase;
  logic [`TL_CNT_W-1:0] remain;
  logic [`TL_CNT_W-1:0] rg_eff;

  input_sync u_input_sync (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_key_plus   (i_key_plus),
    .i_key_sub    (i_key_sub),
    .i_tick       (i_tick),
    .o_plus_pulse (plus_pulse),
    .o_sub_pulse  (sub_pulse),
    .o_sec_pulse  (sec_pulse)
  );

  duration_regs u_duration_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (i_mode),
    .i_plus_pulse (plus_pulse),
    .i_sub_pulse  (sub_pulse),
    .o_rg_len     (rg_len),
    .o_y_len      (y_len)
  );

  day_clock u_day_clock (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sec_pulse (sec_pulse),
    .o_hour      (hour),
    .o_minute    (minute),
    .o_peak      (peak)
  );

  phase_ctrl u_phase_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (i_mode),
    .i_plus_pulse (plus_pulse),
    .i_sub_pulse  (sub_pulse),
    .i_sec_pulse  (sec_pulse),
    .i_rg_len     (rg_len),
    .i_y_len      (y_len),
    .i_peak       (peak),
    .o_phase      (phase),
    .o_remain     (remain),
    .o_rg_eff     (rg_eff)
  );

  lamp_decode u_lamp_decode (
    .i_phase (phase),
    .o_r1    (o_r1),
    .o_y1    (o_y1),
    .o_g1    (o_g1),
    .o_r1_l  (o_r1_l),
    .o_y1_l  (o_y1_l),
    .o_g1_l  (o_g1_l),
    .o_r2    (o_r2),
    .o_y2    (o_y2),
    .o_g2    (o_g2),
    .o_r2_l  (o_r2_l),
    .o_y2_l  (o_y2_l),
    .o_g2_l  (o_g2_l)
  );

  display_select u_display_select (
    .i_mode      (i_mode),
    .i_phase     (phase),
    .i_remain    (remain),
    .i_rg_eff    (rg_eff),
    .i_rg_len    (rg_len),
    .i_y_len     (y_len),
    .i_hour      (hour),
    .i_minute    (minute),
    .o_disp_main (o_disp_main),
    .o_disp_side (o_disp_side)
  );

endmodule

`default_nettype wire

// ==== verification/tb_tl_checks.svh ====
// compare tasks and test counters for the intersection controller testbench
// included inside the testbench module once the DUT signals are declared
`ifndef TB_TL_CHECKS_SVH
`define TB_TL_CHECKS_SVH

int errors = 0;
int checks = 0;
int tests  = 0;

// r1 y1 g1, r1l y1l g1l, r2 y2 g2, r2l y2l g2l
function automatic logic [11:0] lamp_word(input phase_t ph);
  case (ph)
    NIGHT:     return 12'b010_010_010_010;
    G1:        return 12'b001_100_100_100;
    G1Y, INT1: return 12'b010_100_100_100;
    G1L:       return 12'b100_001_100_100;
    G1LY:      return 12'b100_010_100_100;
    G2:        return 12'b100_100_001_100;
    G2Y, INT2: return 12'b100_100_010_100;
    G2L:       return 12'b100_100_100_001;
    G2LY:      return 12'b100_100_100_010;
    default:   return 12'b000_000_000_000;
  endcase
endfunction

task automatic check_lamps(input logic [11:0] got, input logic [11:0] exp, input string name);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic check_disp(input logic [`TL_DISP_W-1:0] got, input logic [`TL_DISP_W-1:0] exp,
                          input string name);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
  end
endtask

task automatic check_phase_lamps(input phase_t ph);
  check_lamps(lamps_w, lamp_word(ph), $sformatf("lamps (%s)", ph.name()));
endtask

task automatic report_test(input string label, input int errs_before);
  tests++;
  if (errors == errs_before) begin
    $display("test %0d %s: ok", tests, label);
  end else begin
    $display("test %0d %s: FAILED", tests, label);
  end
endtask

`endif

// ==== verification/tb_tl_top.sv ====
// testbench for the intersection controller top level
// a row table covers settings, night and interrupts, a phase model covers the run cycle
`default_nettype none
`timescale 1ns/1ps
`include "tl_settings.svh"

module tb_tl_top;

  import tl_pkg::*;

  localparam int ACT_NONE = 0;
  localparam int ACT_PLUS = 1;
  localparam int ACT_SUB  = 2;
  localparam int ACT_TICK = 3;

  typedef struct {
    mode_t  mode;
    int     act;
    int     n;
    phase_t ph;
    bit     chk_disp;
    int     main_v;
    int     side_v;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  mode_t                 mode_r;
  logic                  key_plus;
  logic                  key_sub;
  logic                  tick;
  wire [11:0]            lamps_w;
  logic [`TL_DISP_W-1:0] disp_main;
  logic [`TL_DISP_W-1:0] disp_side;

  // model state, settings as the keys left them and seconds since reset
  int     g_set;
  int     y_set;
  int     tick_total;
  int     seed;
  row_t   rows [$];
  phase_t order [8] = '{G1, G1Y, G1L, G1LY, G2, G2Y, G2L, G2LY};

  `include "tb_tl_checks.svh"

  tl_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_mode      (mode_r),
    .i_key_plus  (key_plus),
    .i_key_sub   (key_sub),
    .i_tick      (tick),
    .o_r1        (lamps_w[11]),
    .o_y1        (lamps_w[10]),
    .o_g1        (lamps_w[9]),
    .o_r1_l      (lamps_w[8]),
    .o_y1_l      (lamps_w[7]),
    .o_g1_l      (lamps_w[6]),
    .o_r2        (lamps_w[5]),
    .o_y2        (lamps_w[4]),
    .o_g2        (lamps_w[3]),
    .o_r2_l      (lamps_w[2]),
    .o_y2_l      (lamps_w[1]),
    .o_g2_l      (lamps_w[0]),
    .o_disp_main (disp_main),
    .o_disp_side (disp_side)
  );

  always #20 clk = ~clk;

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic pulse_tick(input int low_cycles);
    tick = 1'b1;
    wait_cycles(3);
    tick = 1'b0;
    wait_cycles(low_cycles);
    tick_total++;
  endtask

  // random low time of 3 to 6 cycles for the long runs
  task automatic run_ticks(input int n, input bit rnd);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = rnd ? 3 + int'($unsigned($random(seed)) % 4) : 3;
      pulse_tick(gap);
    end
  endtask

  task automatic press_key(input bit plus);
    if (plus) begin
      key_plus = 1'b1;
    end else begin
      key_sub = 1'b1;
    end
    wait_cycles(3);
    key_plus = 1'b0;
    key_sub  = 1'b0;
    wait_cycles(3);
  endtask

  task automatic wait_lamps(input phase_t ph);
    int n;
    n = 0;
    while ((lamps_w !== lamp_word(ph)) && (n < 200)) begin
      wait_cycles(1);
      n++;
    end
    if (lamps_w !== lamp_word(ph)) begin
      errors++;
      $display("timeout at %0d ns: the %s lamps never came on", $time, ph.name());
    end
  endtask

  function automatic int green_eff(input phase_t ph, input bit peak);
    if (peak && ((ph == G1) || (ph == G2))) begin
      return 2 * g_set;
    end
    return g_set;
  endfunction

  function automatic int phase_len(input phase_t ph, input bit peak);
    case (ph)
      G1, G2, G1L, G2L: return green_eff(ph, peak);
      INT1, INT2:       return `TL_INT_LEN;
      default:          return y_set;
    endcase
  endfunction

  function automatic int exp_main(input phase_t ph, input int r, input int g);
    case (ph)
      G1, G1L, G2L: return r + y_set;
      G2:           return r + 2 * y_set + g;
      G2Y:          return r + y_set + g;
      default:      return r;
    endcase
  endfunction

  function automatic int exp_side(input phase_t ph, input int r, input int g);
    case (ph)
      G1:           return r + 2 * y_set + g;
      G1Y:          return r + y_set + g;
      G1L, G2, G2L: return r + y_set;
      default:      return r;
    endcase
  endfunction

  function automatic int clock_disp();
    return ((tick_total / 3600) % 24) * 100 + (tick_total / 60) % 60;
  endfunction

  task automatic add_row(input mode_t m, input int act, input int n, input phase_t ph,
                         input bit chk, input int main_v, input int side_v);
    row_t r;
    r.mode     = m;
    r.act      = act;
    r.n        = n;
    r.ph       = ph;
    r.chk_disp = chk;
    r.main_v   = main_v;
    r.side_v   = side_v;
    rows.push_back(r);
  endtask

  task automatic apply_rows();
    row_t r;
    int   e0;
    while (rows.size() > 0) begin
      r  = rows.pop_front();
      e0 = errors;
      mode_r = r.mode;
      case (r.act)
        ACT_PLUS: press_key(1'b1);
        ACT_SUB:  press_key(1'b0);
        ACT_TICK: run_ticks(r.n, 1'b0);
        default:  ;
      endcase
      // keys only step the setting that the mode selects
      if ((r.mode == SET_RG) && (r.act == ACT_PLUS)) begin
        g_set = g_set + 1;
      end else if ((r.mode == SET_RG) && (r.act == ACT_SUB)) begin
        g_set = g_set - 1;
      end else if ((r.mode == SET_Y) && (r.act == ACT_PLUS)) begin
        y_set = y_set + 1;
      end else if ((r.mode == SET_Y) && (r.act == ACT_SUB)) begin
        y_set = y_set - 1;
      end
      wait_cycles(4);
      check_phase_lamps(r.ph);
      if (r.chk_disp) begin
        check_disp(disp_main, `TL_DISP_W'(r.main_v), "o_disp_main");
        check_disp(disp_side, `TL_DISP_W'(r.side_v), "o_disp_side");
      end
      report_test($sformatf("row in %s", r.ph.name()), e0);
    end
  endtask

  // enters with the count loaded, leaves once the next phase is loaded
  task automatic walk_phase(input phase_t ph, input phase_t nx, input bit peak);
    int len;
    int ge;
    int e0;
    len = phase_len(ph, peak);
    ge  = green_eff(ph, peak);
    e0  = errors;
    check_phase_lamps(ph);
    check_disp(disp_main, `TL_DISP_W'(exp_main(ph, len, ge)), "o_disp_main");
    check_disp(disp_side, `TL_DISP_W'(exp_side(ph, len, ge)), "o_disp_side");
    run_ticks(len - 1, 1'b1);
    wait_cycles(4);
    check_phase_lamps(ph);
    run_ticks(1, 1'b1);
    wait_lamps(nx);
    wait_cycles(2);
    report_test($sformatf("%s lasts %0d ticks", ph.name(), len), e0);
  endtask

  initial begin
    int e0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    mode_r     = NIGHT_MODE;
    key_plus   = 1'b0;
    key_sub    = 1'b0;
    tick       = 1'b0;
    g_set      = `TL_RG_DEFAULT;
    y_set      = `TL_Y_DEFAULT;
    tick_total = 0;
    seed       = 89767;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // defaults and setting adjustment, clock still reads 00:00
    add_row(NIGHT_MODE, ACT_NONE, 0, NIGHT, 1'b1, 0, 0);
    add_row(SET_RG, ACT_NONE, 0, NIGHT, 1'b1, `TL_RG_DEFAULT, 0);
    add_row(SET_Y, ACT_NONE, 0, NIGHT, 1'b1, `TL_Y_DEFAULT, 0);
    add_row(SET_RG, ACT_PLUS, 0, NIGHT, 1'b1, `TL_RG_DEFAULT + 1, 0);
    add_row(SET_RG, ACT_PLUS, 0, NIGHT, 1'b1, `TL_RG_DEFAULT + 2, 0);
    add_row(SET_RG, ACT_PLUS, 0, NIGHT, 1'b1, `TL_RG_DEFAULT + 3, 0);
    add_row(SET_RG, ACT_SUB, 0, NIGHT, 1'b1, `TL_RG_DEFAULT + 2, 0);
    add_row(SET_Y, ACT_SUB, 0, NIGHT, 1'b1, `TL_Y_DEFAULT - 1, 0);
    add_row(SET_Y, ACT_TICK, 3, NIGHT, 1'b1, `TL_Y_DEFAULT - 1, 0);
    add_row(SET_RG, ACT_TICK, 2, NIGHT, 1'b1, `TL_RG_DEFAULT + 2, 0);
    apply_rows();

    // full run cycle from night
    mode_r = RUN;
    wait_lamps(G1);
    wait_cycles(2);
    for (int i = 0; i < 8; i++) begin
      walk_phase(order[i], order[(i + 1) % 8], 1'b0);
    end

    // night in mid phase, then both interrupts
    add_row(RUN, ACT_TICK, 5, G1, 1'b1,
            exp_main(G1, g_set - 5, g_set), exp_side(G1, g_set - 5, g_set));
    add_row(NIGHT_MODE, ACT_NONE, 0, NIGHT, 1'b1, 0, 0);
    add_row(RUN, ACT_NONE, 0, G1, 1'b1, exp_main(G1, g_set, g_set), exp_side(G1, g_set, g_set));
    add_row(RUN, ACT_SUB, 0, INT1, 1'b1, `TL_INT_LEN, `TL_INT_LEN);
    add_row(RUN, ACT_TICK, `TL_INT_LEN - 1, INT1, 1'b1, 1, 1);
    add_row(RUN, ACT_TICK, 1, G1, 1'b1, exp_main(G1, g_set, g_set), exp_side(G1, g_set, g_set));
    add_row(RUN, ACT_PLUS, 0, INT2, 1'b1, `TL_INT_LEN, `TL_INT_LEN);
    add_row(RUN, ACT_TICK, `TL_INT_LEN, G2, 1'b1,
            exp_main(G2, g_set, g_set), exp_side(G2, g_set, g_set));
    apply_rows();

    // run the clock up to 07:00 with the phase frozen
    mode_r = SET_RG;
    run_ticks(25200 - tick_total, 1'b1);
    wait_cycles(4);
    e0 = errors;
    check_disp(disp_side, `TL_DISP_W'(clock_disp()), "o_disp_side");
    check_disp(disp_main, `TL_DISP_W'(g_set), "o_disp_main");
    report_test("clock at 07:00", e0);

    // through green doubles, left turn keeps the single length
    mode_r = NIGHT_MODE;
    wait_cycles(4);
    mode_r = RUN;
    wait_lamps(G1);
    wait_cycles(2);
    walk_phase(G1, G1Y, 1'b1);
    walk_phase(G1Y, G1L, 1'b1);
    walk_phase(G1L, G1LY, 1'b1);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
+incdir+verification
logic/tl_pkg.sv
logic/input_sync.sv
logic/duration_regs.sv
logic/day_clock.sv
logic/phase_ctrl.sv
logic/lamp_decode.sv
logic/display_select.sv
logic/tl_top.sv
verification/tb_tl_top.sv

// ==== Makefile ====
# Verilator build and run for the intersection controller testbench

TOP := tb_tl_top
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
